/* common/contact_pkg.sv */
package contact_pkg;

  typedef logic [31:0] fp32_t;   // ieee-754 single precision bit pattern
  typedef logic [7:0]  tag_t;    // triangle tag carried with a request
  typedef logic [15:0] count_t;  // statistics counter width

  typedef struct packed {
    fp32_t u;    // barycentric u
    fp32_t v;    // barycentric v
    fp32_t det;  // determinant from the setup stage
    tag_t  tag;  // returned untouched in the response
  } contact_req_t;

  typedef struct packed {
    tag_t tag;  // tag of the request this answers
    logic hit;  // all five contact conditions held
  } contact_rsp_t;

  localparam fp32_t FP_ONE     = 32'h3f80_0000;  // 1.0
  localparam fp32_t FP_EPSILON = 32'h322b_cc77;  // 1e-8, smallest det that counts as contact

  localparam int unsigned ADD_LATENCY = 3;  // enabled cycles through fp_add
  localparam int unsigned CMP_LATENCY = 2;  // flag register then hit register

  typedef enum logic {
    IDLE,   // waiting for start
    COUNT   // stepping the adder and compare pipeline
  } detect_state_t;

  // signed magnitude less-than, +0 and -0 compare equal
  function automatic logic fp_less(input fp32_t a, input fp32_t b);
    logic a_zero;
    logic b_zero;
    a_zero = (a[30:0] == 31'd0);
    b_zero = (b[30:0] == 31'd0);
    if (a_zero && b_zero) begin
      return 1'b0;  // both zero regardless of sign
    end
    if (a[31] != b[31]) begin
      return a[31];  // negative side is the smaller one
    end
    // same sign: magnitude order, reversed for negatives
    if (a[31]) begin
      return a[30:0] > b[30:0];
    end
    return a[30:0] < b[30:0];
  endfunction

  function automatic logic fp_greater(input fp32_t a, input fp32_t b);
    return fp_less(b, a);  // a > b is b < a
  endfunction

endpackage

/* contact/contact_detect.sv */
`timescale 1ns/1ps

module contact_detect (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  contact_pkg::contact_req_t  req,
  output logic                       done,
  output logic                       busy,
  output contact_pkg::contact_rsp_t  rsp
);
  import contact_pkg::*;

  // one flag per failed contact condition
  typedef struct packed {
    logic u_neg;      // u < 0
    logic v_neg;      // v < 0
    logic det_small;  // det < epsilon
    logic u_big;      // u > 1
    logic sum_big;    // u + v > 1
  } miss_t;

  localparam int unsigned LAST_STEP = ADD_LATENCY + CMP_LATENCY;  // step that raises done

  detect_state_t state;
  detect_state_t state_nxt;
  logic [$clog2(LAST_STEP + 2)-1:0] step;  // cycles since acceptance
  logic [$clog2(LAST_STEP + 2)-1:0] step_nxt;
  logic         accept;   // start seen while idle
  logic         en;       // adder advance
  contact_req_t held;     // request captured at accept
  fp32_t        sum;      // u + v from the adder
  miss_t        miss;     // compare results on current operands
  miss_t        miss_q;   // first compare stage
  logic         hit_q;    // second compare stage

  assign accept = (state == IDLE) && start;
  assign busy = (state == COUNT);
  assign en = (state == COUNT) && (step < ADD_LATENCY);  // three enabled cycles

  always_comb begin
    state_nxt = state;
    step_nxt = step;
    case (state)
      IDLE: begin
        if (start) begin
          state_nxt = COUNT;
          step_nxt = '0;
        end
      end
      COUNT: begin
        if (step == LAST_STEP + 1) begin
          state_nxt = IDLE;  // done cycle is over, stay busy through it
        end else begin
          step_nxt = step + 1'b1;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
      step <= '0;
    end else begin
      state <= state_nxt;
      step <= step_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held <= req;  // operands stay stable for the whole test
    end
  end

  fp_add u_add (
    .clk (clk),
    .rst (rst),
    .en  (en),
    .a   (held.u),
    .b   (held.v),
    .sum (sum)
  );

  // comparisons against constants, sum settles after the third enabled cycle
  always_comb begin
    miss.u_neg = fp_less(held.u, 32'd0);
    miss.v_neg = fp_less(held.v, 32'd0);
    miss.det_small = fp_less(held.det, FP_EPSILON);
    miss.u_big = fp_greater(held.u, FP_ONE);
    miss.sum_big = fp_greater(sum, FP_ONE);
  end

  always_ff @(posedge clk) begin
    miss_q <= miss;     // flags stage
    hit_q <= ~|miss_q;  // hit stage, any miss rejects
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done <= 1'b0;
      rsp <= '0;
    end else begin
      done <= (state == COUNT) && (step == LAST_STEP);
      if ((state == COUNT) && (step == LAST_STEP)) begin
        rsp.tag <= held.tag;
        rsp.hit <= hit_q;  // held until the next done
      end
    end
  end

endmodule

/* logic/contact_unit.sv */
`timescale 1ns/1ps

module contact_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  contact_pkg::contact_req_t  req,
  output logic                       done,
  output logic                       busy,
  output contact_pkg::contact_rsp_t  rsp,
  output contact_pkg::count_t        test_count,
  output contact_pkg::count_t        hit_count
);

  contact_detect u_detect (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .req   (req),
    .done  (done),
    .busy  (busy),
    .rsp   (rsp)
  );

  // statistics, both stick at all ones
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      test_count <= '0;
      hit_count <= '0;
    end else if (done) begin
      if (test_count != '1) begin
        test_count <= test_count + 1'b1;  // every completed test
      end
      if (rsp.hit && (hit_count != '1)) begin
        hit_count <= hit_count + 1'b1;    // only the hits
      end
    end
  end

endmodule

/* logic/fp_add.sv */
`timescale 1ns/1ps

module fp_add (
  input  logic                clk,
  input  logic                rst,
  input  logic                en,
  input  contact_pkg::fp32_t  a,
  input  contact_pkg::fp32_t  b,
  output contact_pkg::fp32_t  sum
);
  import contact_pkg::*;

  // stage 1 combinational: order and align
  logic        swap;          // b has the larger magnitude
  fp32_t       op_big;        // larger magnitude operand
  fp32_t       op_small;      // smaller magnitude operand
  logic [23:0] mant_big;      // with hidden bit, denormals flushed
  logic [23:0] mant_small;
  logic [7:0]  exp_diff;      // alignment shift
  logic [49:0] shift_wide;    // small mantissa with room for shifted-out bits
  logic [26:0] small_aligned; // mantissa, guard, round, sticky

  // stage 1 registers
  logic        s1_sign;
  logic        s1_sub;        // operand signs differ
  logic [7:0]  s1_exp;
  logic [26:0] s1_big;
  logic [26:0] s1_small;

  // stage 2 registers
  logic        s2_sign;
  logic [7:0]  s2_exp;
  logic [27:0] s2_mant;       // bit 27 is the carry out of an add

  // stage 3 combinational: normalise and round
  logic        mant_zero;     // exact cancellation or zero operands
  logic [4:0]  lead_zeros;    // leading zeros below the carry bit
  logic [26:0] norm;          // hidden bit at 26, grs in [2:0]
  logic [9:0]  norm_exp;      // extra bits catch overflow
  logic        underflow;     // below the normal range, flushed
  logic        round_up;
  logic [24:0] rounded;       // carry out means mantissa overflowed
  logic [9:0]  final_exp;
  fp32_t       result;

  always_comb begin
    swap = b[30:0] > a[30:0];  // exponent then mantissa, so raw bits order
    op_big = swap ? b : a;
    op_small = swap ? a : b;
    mant_big = (op_big[30:23] == 8'd0) ? 24'd0 : {1'b1, op_big[22:0]};
    mant_small = (op_small[30:23] == 8'd0) ? 24'd0 : {1'b1, op_small[22:0]};
    exp_diff = op_big[30:23] - op_small[30:23];
    if (exp_diff > 8'd26) begin
      shift_wide = '0;  // shifted past round bit, only sticky survives
      small_aligned = {26'd0, |mant_small};
    end else begin
      shift_wide = {mant_small, 26'd0} >> exp_diff;
      small_aligned = {shift_wide[49:24], |shift_wide[23:0]};  // fold lost bits into sticky
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_sign <= 1'b0;
      s1_sub <= 1'b0;
      s1_exp <= '0;
      s1_big <= '0;
      s1_small <= '0;
    end else if (en) begin
      s1_sign <= op_big[31];  // result takes the sign of the larger magnitude
      s1_sub <= a[31] ^ b[31];
      s1_exp <= op_big[30:23];
      s1_big <= {mant_big, 3'b000};
      s1_small <= small_aligned;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s2_sign <= 1'b0;
      s2_exp <= '0;
      s2_mant <= '0;
    end else if (en) begin
      s2_sign <= s1_sign;
      s2_exp <= s1_exp;
      if (s1_sub) begin
        s2_mant <= {1'b0, s1_big} - {1'b0, s1_small};  // big >= small, never negative
      end else begin
        s2_mant <= {1'b0, s1_big} + {1'b0, s1_small};
      end
    end
  end

  always_comb begin
    mant_zero = (s2_mant == 28'd0);
    lead_zeros = '0;
    for (int i = 0; i < 27; i++) begin
      if (s2_mant[i]) begin
        lead_zeros = 5'(26 - i);  // highest set bit wins
      end
    end
    if (s2_mant[27]) begin
      norm = {s2_mant[27:2], s2_mant[1] | s2_mant[0]};  // shift right one, keep sticky
      norm_exp = {2'b00, s2_exp} + 10'd1;
      underflow = 1'b0;
    end else begin
      norm = s2_mant[26:0] << lead_zeros;
      norm_exp = {2'b00, s2_exp} - {5'd0, lead_zeros};
      underflow = ({5'd0, lead_zeros} >= {2'b00, s2_exp});  // exponent would reach zero
    end
    round_up = norm[2] & (norm[1] | norm[0] | norm[3]);  // nearest, ties to even
    rounded = {1'b0, norm[26:3]} + {24'd0, round_up};
    final_exp = rounded[24] ? norm_exp + 10'd1 : norm_exp;
    if (underflow || mant_zero) begin
      result = '0;  // flush to zero
    end else if (final_exp >= 10'd255) begin
      result = {s2_sign, 8'hff, 23'd0};  // overflow to infinity
    end else if (rounded[24]) begin
      result = {s2_sign, final_exp[7:0], rounded[23:1]};
    end else begin
      result = {s2_sign, final_exp[7:0], rounded[22:0]};
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sum <= '0;
    end else if (en) begin
      sum <= result;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build the contact unit testbench with Verilator and run it
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module contact_tb -f sources.f -o contact_sim \
  || { echo "verilator build failed"; exit 1; }

# raise the error limit so assertion errors do not stop the run early
sim_out=$(./obj_dir/contact_sim +verilator+error+limit+1000)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* sources.f */
common/contact_pkg.sv
logic/fp_add.sv
contact/contact_detect.sv
logic/contact_unit.sv
verif/contact_assert.sv
verif/contact_tb.sv

/* verif/contact_assert.sv */
`timescale 1ns/1ps

module contact_assert (
  input logic                       clk,
  input logic                       rst,
  input logic                       start,
  input contact_pkg::contact_req_t  req,
  input logic                       done,
  input logic                       busy,
  input contact_pkg::contact_rsp_t  rsp,
  input contact_pkg::count_t        test_count,
  input contact_pkg::count_t        hit_count
);
  import contact_pkg::*;

  logic        accept;      // start that the unit takes
  int unsigned violations;  // failed properties, read by the testbench

  initial violations = 0;

  assign accept = start && !busy;  // idle is exactly not busy

  // done is a register output, seen here one edge after it rises
  a_done_after_start: assert property (@(posedge clk) disable iff (rst)
      accept |-> ##(ADD_LATENCY + CMP_LATENCY + 2) done)
    else begin
      violations++;
      $error("no done at the expected cycle after an accepted start");
    end

  a_done_source: assert property (@(posedge clk) disable iff (rst)
      done |-> $past(accept, ADD_LATENCY + CMP_LATENCY + 2) &&
               (rsp.tag == $past(req.tag, ADD_LATENCY + CMP_LATENCY + 2)))
    else begin
      violations++;
      $error("done without a matching accepted start, or wrong tag");
    end

  a_done_single: assert property (@(posedge clk) disable iff (rst)
      done |=> !done && !busy)  // one cycle strobe, busy ends with it
    else begin
      violations++;
      $error("done longer than one cycle or busy stuck after done");
    end

  a_busy_rise: assert property (@(posedge clk) disable iff (rst)
      accept |=> busy)
    else begin
      violations++;
      $error("busy not raised after an accepted start");
    end

  a_busy_hold: assert property (@(posedge clk) disable iff (rst)
      busy && !done |=> busy)  // stays up through the done cycle
    else begin
      violations++;
      $error("busy dropped before done");
    end

  a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
      !done |-> $stable(rsp))
    else begin
      violations++;
      $error("response changed outside a done cycle");
    end

  a_count_step: assert property (@(posedge clk) disable iff (rst)
      done |=> (test_count == count_t'($past(test_count) + 1'b1)) &&
               (hit_count == count_t'($past(hit_count) + $past(rsp.hit))))
    else begin
      violations++;
      $error("counters did not step on done");
    end

  a_count_hold: assert property (@(posedge clk) disable iff (rst)
      !done |=> $stable(test_count) && $stable(hit_count))
    else begin
      violations++;
      $error("counters moved without done");
    end

  a_reset_state: assert property (@(posedge clk)
      $fell(rst) |-> !done && !busy && (rsp == '0) &&
                     (test_count == '0) && (hit_count == '0))
    else begin
      violations++;
      $error("outputs not cleared when reset is released");
    end

endmodule

bind contact_unit contact_assert u_assert (
  .clk        (clk),
  .rst        (rst),
  .start      (start),
  .req        (req),
  .done       (done),
  .busy       (busy),
  .rsp        (rsp),
  .test_count (test_count),
  .hit_count  (hit_count)
);

/* verif/contact_tb.sv */
`timescale 1ns/1ps

module contact_tb;
  import contact_pkg::*;

  logic         clk = 1'b0;
  logic         rst;
  logic         start;
  contact_req_t req;
  logic         done;
  logic         busy;
  contact_rsp_t rsp;
  count_t       test_count;
  count_t       hit_count;

  int           seed = 36;                           // $random seed
  int unsigned  random_count = 200;                  // back to back requests
  int unsigned  cycle_limit = 8 + 20 * (7 + 200 + 1);  // reset plus 20 per request
  int unsigned  cycles = 0;
  int unsigned  errors = 0;
  int unsigned  seen = 0;          // responses taken off the queue
  int unsigned  seen_hits = 0;
  int unsigned  group_seen = 0;
  int unsigned  group_errors = 0;
  logic         counts_due = 1'b0; // counters settle one edge after done
  contact_rsp_t expected;
  contact_rsp_t exp_q[$];          // one entry per accepted start

  contact_unit u_dut (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .req        (req),
    .done       (done),
    .busy       (busy),
    .rsp        (rsp),
    .test_count (test_count),
    .hit_count  (hit_count)
  );

  always #50 clk = ~clk;  // 100 ns period

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // decode a single precision pattern, exponent zero reads as zero
  function automatic real to_real(input fp32_t f);
    real mag;
    int  e;
    if (f[30:23] == 8'd0) begin
      return 0.0;  // also turns -0 into +0
    end
    mag = 1.0 + real'(f[22:0]) / 8388608.0;
    e = int'(f[30:23]) - 127;
    while (e > 0) begin
      mag = mag * 2.0;
      e--;
    end
    while (e < 0) begin
      mag = mag / 2.0;
      e++;
    end
    return f[31] ? -mag : mag;
  endfunction

  // reference rule: u, v >= 0, det >= eps, u <= 1, u + v <= 1
  function automatic contact_rsp_t expect_of(input contact_req_t r);
    real          u;
    real          v;
    real          det;
    contact_rsp_t e;
    u = to_real(r.u);
    v = to_real(r.v);
    det = to_real(r.det);
    e.tag = r.tag;
    e.hit = (u >= 0.0) && (v >= 0.0) && (det >= to_real(FP_EPSILON)) &&
            (u <= 1.0) && (u + v <= 1.0);
    return e;
  endfunction

  function automatic contact_req_t make_req(input fp32_t u, input fp32_t v,
                                            input fp32_t det, input tag_t tag);
    contact_req_t r;
    r.u = u;
    r.v = v;
    r.det = det;
    r.tag = tag;
    return r;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic fp32_t rand_coord();
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] mant;
    sign = (pick(8) == 0);       // one in eight negative
    exp = 8'(118 + pick(10));    // about 2^-9 up to just under 2
    mant = 23'($random(seed));
    return {sign, exp, mant};
  endfunction

  function automatic fp32_t rand_det();
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] mant;
    sign = (pick(16) == 0);
    exp = 8'(96 + pick(16));     // straddles the epsilon exponent of 100
    mant = 23'($random(seed));
    return {sign, exp, mant};
  endfunction

  // sums this close to one could round across the boundary
  function automatic logic near_one(input fp32_t u, input fp32_t v);
    real s;
    s = to_real(u) + to_real(v) - 1.0;
    return (s < 1.0e-6) && (s > -1.0e-6);
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    group_errors++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  // response checker, sampled away from the rising edge
  always @(negedge clk) begin
    if (!rst) begin
      if (counts_due) begin
        counts_due = 1'b0;
        if (test_count != count_t'(seen) || hit_count != count_t'(seen_hits)) begin
          report_mismatch($sformatf("counters %0d tests %0d hits, expected %0d and %0d",
                                    test_count, hit_count, seen, seen_hits));
        end
      end
      if (done) begin
        if (exp_q.size() == 0) begin
          errors++;
          group_errors++;
          $display("done at %0t ns although no accepted request was pending", $time);
        end else begin
          expected = exp_q.pop_front();
          seen++;
          group_seen++;
          seen_hits += expected.hit;
          counts_due = 1'b1;
          if (rsp !== expected) begin
            report_mismatch($sformatf("tag %0d hit %0b, expected tag %0d hit %0b",
                                      rsp.tag, rsp.hit, expected.tag, expected.hit));
          end
        end
      end
    end
  end

  task automatic wait_done();
    @(negedge clk);
    while (!done) begin
      @(negedge clk);  // the cycle counter bounds this wait
    end
  endtask

  // one start strobe, then wait for its answer
  task automatic send(input contact_req_t r);
    @(posedge clk);
    start <= 1'b1;
    req <= r;
    exp_q.push_back(expect_of(r));
    @(posedge clk);
    start <= 1'b0;
    req <= ~r;  // garbage after the start cycle
    wait_done();
  endtask

  task automatic report_group(input string name);
    repeat (2) @(negedge clk);
    $display("test %s finished: %0d responses, %0d errors", name, group_seen, group_errors);
    group_seen = 0;
    group_errors = 0;
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    if (done || busy || (rsp != '0) || (test_count != '0) || (hit_count != '0)) begin
      report_mismatch("outputs not zero after reset");
    end
    report_group("reset");
  endtask

  task automatic run_boundary();
    send(make_req(32'h3f00_0000, 32'h3f00_0000, FP_ONE, 8'hd0));  // 0.5 + 0.5 is one
    send(make_req(32'h3f40_0000, 32'h3f00_0000, FP_ONE, 8'hd1));  // 0.75 + 0.5
    send(make_req(32'hbe80_0000, 32'h3e80_0000, FP_ONE, 8'hd2));  // u = -0.25
    send(make_req(32'h3e80_0000, 32'h8000_0000, FP_ONE, 8'hd3));  // v = -0.0
    send(make_req(32'h3fc0_0000, 32'h0000_0000, FP_ONE, 8'hd4));  // u = 1.5
    send(make_req(32'h3e80_0000, 32'h3e80_0000, 32'h3089_705f, 8'hd5));  // det 1e-9
    send(make_req(32'h3e80_0000, 32'h3e80_0000, FP_EPSILON, 8'hd6));
    report_group("boundary");
  endtask

  task automatic run_random();
    contact_req_t r;
    for (int i = 0; i < random_count; i++) begin
      r.u = rand_coord();
      r.v = rand_coord();
      while (near_one(r.u, r.v)) begin
        r.v = rand_coord();
      end
      r.det = rand_det();
      r.tag = tag_t'(i);
      send(r);
    end
    report_group("random");
  endtask

  // edge counts follow the fixed six cycle answer time
  task automatic run_busy();
    contact_req_t a;
    a = make_req(32'h3e80_0000, 32'h3e80_0000, FP_ONE, 8'ha5);
    @(posedge clk);
    start <= 1'b1;
    req <= a;
    exp_q.push_back(expect_of(a));
    @(posedge clk);             // accepting edge
    start <= 1'b0;
    req <= ~a;
    @(posedge clk);
    start <= 1'b1;              // lands mid test
    req <= make_req(32'hbf80_0000, 32'h3f00_0000, 32'd0, 8'h5a);
    @(posedge clk);
    start <= 1'b0;
    repeat (4) @(posedge clk);  // edge that raises done
    start <= 1'b1;
    req <= make_req(32'h3f00_0000, 32'h3f00_0000, FP_ONE, 8'h3c);
    @(negedge clk);
    if (!done) begin
      errors++;
      group_errors++;
      $display("second ignored start did not line up with the done cycle");
    end
    @(posedge clk);
    start <= 1'b0;
    repeat (12) @(negedge clk);
    if (group_seen != 1) begin
      errors++;
      group_errors++;
      $display("starts during busy changed the number of responses to %0d", group_seen);
    end
    report_group("busy");
  endtask

  task automatic check_final_counts();
    @(negedge clk);
    if (test_count != count_t'(seen) || hit_count != count_t'(seen_hits)) begin
      report_mismatch($sformatf("final counters %0d and %0d, expected %0d and %0d",
                                test_count, hit_count, seen, seen_hits));
    end
    if (exp_q.size() != 0) begin
      errors++;
      group_errors++;
      $display("%0d accepted requests were never answered", exp_q.size());
    end
    report_group("counters");
  endtask

  initial begin
    rst = 1'b1;
    start = 1'b0;
    req = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    check_reset_state();
    run_boundary();
    run_random();
    run_busy();
    check_final_counts();
    $display("responses %0d, hits %0d, errors %0d, assertion failures %0d",
             seen, seen_hits, errors, u_dut.u_assert.violations);
    if (errors == 0 && u_dut.u_assert.violations == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
